// File: logic/routerPkg.sv
package routerPkg;

  // port order is Local, North, East, West, South
  localparam int numPorts = 5;
  localparam int portIdxWidth = 3;

  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12;
  localparam int dataWidth = 16;

  localparam int queueDepth = 4;

  // flit type that carries the grant time limit
  localparam logic [flitIdWidth-1:0] headerId = 3'b001;

  // one-hot, bit 0 is idle and bit p+1 means input p holds the grant
  localparam int stateWidth = numPorts + 1;

endpackage

// File: logic/inputQueue.sv
module inputQueue
  import routerPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push,
  input  logic [flitIdWidth-1:0] pushId,
  input  logic [lengthWidth-1:0] pushLength,
  input  logic [dataWidth-1:0]   pushData,
  input  logic                   pop,
  output logic [flitIdWidth-1:0] headId,
  output logic [lengthWidth-1:0] headLength,
  output logic [dataWidth-1:0]   headData,
  output logic                   empty,
  output logic                   full
);

  logic [flitIdWidth+lengthWidth+dataWidth-1:0] mem [queueDepth];
  logic [$clog2(queueDepth)-1:0] wrPtr;
  logic [$clog2(queueDepth)-1:0] rdPtr;
  logic [$clog2(queueDepth+1)-1:0] count;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= {pushId, pushLength, pushData};
  end

  // pop is trusted, the switch only pops a non-empty queue
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == queueDepth - 1) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == queueDepth - 1) ? '0 : rdPtr + 1'b1;
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // oldest entry shown without a read cycle
  assign {headId, headLength, headData} = mem[rdPtr];

  assign empty = (count == 0);
  assign full = (count == queueDepth);

endmodule

// File: logic/portTimer.sv
module portTimer
  import routerPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [flitIdWidth-1:0] flitId,
  input  logic [lengthWidth-1:0] length,
  input  logic                   runTimer,
  output logic                   timesUp
);

  logic [lengthWidth-1:0] limit;
  logic [lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // only a header flit at the queue head sets the limit
      if (flitId == headerId)
        limit <= length;
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == limit);

endmodule

// File: logic/flowArbiter.sv
module flowArbiter
  import routerPkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [numPorts-1:0]                   request,
  input  logic [numPorts-1:0][flitIdWidth-1:0]  headId,
  input  logic [numPorts-1:0][lengthWidth-1:0]  headLength,
  output logic [numPorts-1:0]                   grant
);

  logic [stateWidth-1:0] state;
  logic [stateWidth-1:0] nextState;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;
  logic [numPorts-1:0][flitIdWidth-1:0] validId;
  logic [portIdxWidth-1:0] holder;
  logic [portIdxWidth-1:0] searchStart;
  logic [portIdxWidth-1:0] candidate;
  logic found;
  logic idle;

  function automatic logic [portIdxWidth-1:0] wrapIdx(
    input logic [portIdxWidth-1:0] base,
    input int offset
  );
    int sum;
    sum = int'(base) + offset;
    if (sum >= numPorts)
      sum = sum - numPorts;
    return portIdxWidth'(sum);
  endfunction

  assign idle = state[0];
  assign grant = state[stateWidth-1:1];

  always_comb
  begin
    holder = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
        holder = portIdxWidth'(i);
    end
  end

  // rotate past the holder, so the holder is checked last
  assign searchStart = (idle || holder == numPorts - 1) ? '0 : holder + 1'b1;

  always_comb
  begin
    found = 1'b0;
    candidate = '0;
    for (int off = 0; off < numPorts; off++)
    begin
      if (!found && request[wrapIdx(searchStart, off)])
      begin
        found = 1'b1;
        candidate = wrapIdx(searchStart, off);
      end
    end
  end

  always_comb
  begin
    runTimer = '0;
    nextState = stateWidth'(1);
    if (!idle && request[holder] && !timesUp[holder])
    begin
      runTimer[holder] = 1'b1;
      nextState = state;
    end
    else if (found)
    begin
      // a re-grant of the holder passes here with runTimer low, so its count restarts
      nextState = stateWidth'(2) << candidate;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stateWidth'(1);
    else
      state <= nextState;
  end

  for (genvar p = 0; p < numPorts; p++)
  begin : genTimer
    // stale entries of an empty queue must not reload the limit
    assign validId[p] = request[p] ? headId[p] : '0;

    portTimer timerInst (
      .clk      (clk),
      .rst      (rst),
      .flitId   (validId[p]),
      .length   (headLength[p]),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

endmodule

// File: logic/outputSwitch.sv
module outputSwitch
  import routerPkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [numPorts-1:0]                   grant,
  input  logic [numPorts-1:0]                   empty,
  input  logic [numPorts-1:0][flitIdWidth-1:0]  headId,
  input  logic [numPorts-1:0][lengthWidth-1:0]  headLength,
  input  logic [numPorts-1:0][dataWidth-1:0]    headData,
  output logic [numPorts-1:0]                   pop,
  output logic                                  outValid,
  output logic [flitIdWidth-1:0]                outId,
  output logic [lengthWidth-1:0]                outLength,
  output logic [dataWidth-1:0]                  outData,
  output logic [portIdxWidth-1:0]               outSource
);

  logic [portIdxWidth-1:0] selIdx;
  logic selValid;

  always_comb
  begin
    selIdx = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
        selIdx = portIdxWidth'(i);
    end
  end

  // the flit is taken from the queue on the same edge it is registered
  assign pop = grant & ~empty;
  assign selValid = |pop;

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selValid;
  end

  always_ff @(posedge clk)
  begin
    if (selValid)
    begin
      outId <= headId[selIdx];
      outLength <= headLength[selIdx];
      outData <= headData[selIdx];
      outSource <= selIdx;
    end
  end

endmodule

// File: logic/routerOutputPort.sv
module routerOutputPort
  import routerPkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [numPorts-1:0]                   inValid,
  input  logic [numPorts-1:0][flitIdWidth-1:0]  inId,
  input  logic [numPorts-1:0][lengthWidth-1:0]  inLength,
  input  logic [numPorts-1:0][dataWidth-1:0]    inData,
  output logic [numPorts-1:0]                   inFull,
  output logic                                  outValid,
  output logic [flitIdWidth-1:0]                outId,
  output logic [lengthWidth-1:0]                outLength,
  output logic [dataWidth-1:0]                  outData,
  output logic [portIdxWidth-1:0]               outSource
);

  logic [numPorts-1:0] empty;
  logic [numPorts-1:0] pop;
  logic [numPorts-1:0] grant;
  logic [numPorts-1:0][flitIdWidth-1:0] headId;
  logic [numPorts-1:0][lengthWidth-1:0] headLength;
  logic [numPorts-1:0][dataWidth-1:0] headData;

  for (genvar p = 0; p < numPorts; p++)
  begin : genQueue
    inputQueue queueInst (
      .clk        (clk),
      .rst        (rst),
      .push       (inValid[p]),
      .pushId     (inId[p]),
      .pushLength (inLength[p]),
      .pushData   (inData[p]),
      .pop        (pop[p]),
      .headId     (headId[p]),
      .headLength (headLength[p]),
      .headData   (headData[p]),
      .empty      (empty[p]),
      .full       (inFull[p])
    );
  end

  // a non-empty queue requests the output link
  flowArbiter arbiterInst (
    .clk        (clk),
    .rst        (rst),
    .request    (~empty),
    .headId     (headId),
    .headLength (headLength),
    .grant      (grant)
  );

  outputSwitch switchInst (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .empty      (empty),
    .headId     (headId),
    .headLength (headLength),
    .headData   (headData),
    .pop        (pop),
    .outValid   (outValid),
    .outId      (outId),
    .outLength  (outLength),
    .outData    (outData),
    .outSource  (outSource)
  );

endmodule

// File: test/routerOutputPort_assertions.sv
module routerOutputPortAssertions
  import routerPkg::*;
(
  input logic                    clk,
  input logic                    rst,
  input logic [numPorts-1:0]     inValid,
  input logic [numPorts-1:0]     inFull,
  input logic [numPorts-1:0]     grant,
  input logic                    outValid,
  input logic [portIdxWidth-1:0] outSource
);
  timeunit 1ns;
  timeprecision 1ps;

  // source index is registered together with the valid bit
  sourceKnown: assert property (@(posedge clk) disable iff (rst)
    outValid |-> !$isunknown(outSource))
  else $error("outValid is high while outSource is unknown");

  // upstream must hold off while a queue is full
  noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
    (inValid & inFull) == '0)
  else $error("a queue was written while its full level was high");

  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant))
  else $error("more than one input holds the grant");

endmodule

bind routerOutputPort routerOutputPortAssertions assertionsInst (
  .clk       (clk),
  .rst       (rst),
  .inValid   (inValid),
  .inFull    (inFull),
  .grant     (grant),
  .outValid  (outValid),
  .outSource (outSource)
);

// File: test/routerOutputPort_tb.sv
module routerOutputPort_tb
  import routerPkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [flitIdWidth+lengthWidth+dataWidth-1:0] flitWord;
  typedef logic [portIdxWidth+flitIdWidth+lengthWidth+dataWidth-1:0] linkWord;

  logic clk;
  logic rst;
  logic [numPorts-1:0] inValid;
  logic [numPorts-1:0][flitIdWidth-1:0] inId;
  logic [numPorts-1:0][lengthWidth-1:0] inLength;
  logic [numPorts-1:0][dataWidth-1:0] inData;
  logic [numPorts-1:0] inFull;
  logic outValid;
  logic [flitIdWidth-1:0] outId;
  logic [lengthWidth-1:0] outLength;
  logic [dataWidth-1:0] outData;
  logic [portIdxWidth-1:0] outSource;

  // flits still to be written, per input
  flitWord pending [numPorts][$];
  flitWord modelQ [numPorts][$];
  logic [lengthWidth-1:0] modelLimit [numPorts];
  linkWord expected [$];
  linkWord got [$];
  logic [31:0] rngState = 32'ha538;
  int cycles = 0;
  int firstWrite;
  int firstOut;
  bit sawSouthFull;
  string testName;
  int errorsAtStart;
  int tests = 0;
  int checks = 0;
  int errors = 0;

  routerOutputPort routerOutputPort_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    // roughly twice the worst-case flit count of all tests times length+1
    if (cycles >= 2000)
    begin
      $display("timeout: the output link stopped delivering flits after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // body flits carry random length fields that must never reach the timer
  task automatic addPacket(int port, int headerLength, int bodies);
    logic [31:0] r;
    r = nextRandom();
    pending[port].push_back({headerId, lengthWidth'(headerLength), r[dataWidth-1:0]});
    for (int b = 0; b < bodies; b++)
    begin
      r = nextRandom();
      pending[port].push_back({3'b010, r[31:20], r[dataWidth-1:0]});
    end
  endtask

  task automatic stepCycle();
    flitWord word;
    @(posedge clk);
    #1;
    if (outValid)
    begin
      got.push_back({outSource, outId, outLength, outData});
      if (firstOut < 0)
        firstOut = cycles;
    end
    if (inFull[numPorts-1])
      sawSouthFull = 1'b1;
    for (int p = 0; p < numPorts; p++)
    begin
      inValid[p] = 1'b0;
      if (pending[p].size() > 0 && !inFull[p])
      begin
        word = pending[p].pop_front();
        {inId[p], inLength[p], inData[p]} = word;
        inValid[p] = 1'b1;
        // the write lands on the next edge
        if (firstWrite < 0)
          firstWrite = cycles + 1;
      end
    end
  endtask

  task automatic buildExpected();
    int holder;
    int next;
    int sent;
    flitWord head;
    expected.delete();
    for (int p = 0; p < numPorts; p++)
      modelQ[p] = pending[p];
    holder = -1;
    next = 0;
    while (next >= 0)
    begin
      // search starts after the holder, the holder itself comes last
      next = -1;
      for (int off = numPorts; off >= 1; off--)
      begin
        if (modelQ[(holder + off) % numPorts].size() > 0)
          next = (holder + off) % numPorts;
      end
      if (next >= 0)
      begin
        head = modelQ[next][0];
        if (head[dataWidth+lengthWidth +: flitIdWidth] == headerId)
          modelLimit[next] = head[dataWidth +: lengthWidth];
        // a run ends after length+1 flits or when the queue runs dry
        sent = 0;
        while (modelQ[next].size() > 0 && sent <= int'(modelLimit[next]))
        begin
          head = modelQ[next].pop_front();
          expected.push_back({portIdxWidth'(next), head});
          sent++;
        end
        holder = next;
      end
    end
  endtask

  task automatic checkValue(string what, logic [63:0] expValue, logic [63:0] actValue);
    checks++;
    assert (actValue === expValue)
    else
    begin
      $display("[FAIL] %s %s: expected %h, got %h", testName, what, expValue, actValue);
      errors++;
    end
  endtask

  task automatic runTraffic(string name);
    testName = name;
    errorsAtStart = errors;
    firstWrite = -1;
    firstOut = -1;
    sawSouthFull = 1'b0;
    buildExpected();
    got.delete();
    while (got.size() < expected.size())
      stepCycle();
    // extra cycles catch stray flits and let the arbiter go idle
    repeat (6) stepCycle();
    checkValue("flit count", expected.size(), got.size());
    for (int i = 0; i < expected.size() && i < got.size(); i++)
      checkValue($sformatf("flit %0d", i), expected[i], got[i]);
  endtask

  task automatic reportTest();
    tests++;
    $display("%-14s %s", testName, (errors == errorsAtStart) ? "ok" : "has errors");
  endtask

  task automatic testReset();
    testName = "reset state";
    errorsAtStart = errors;
    repeat (5)
    begin
      stepCycle();
      checkValue("outValid", 0, outValid);
      checkValue("inFull", 0, inFull);
    end
    reportTest();
  endtask

  task automatic testSingle();
    addPacket(1, 3, 3);
    runTraffic("single input");
    checkValue("first flit latency", firstWrite + 2, firstOut);
    reportTest();
  endtask

  task automatic testOrder();
    for (int p = 0; p < numPorts; p++)
      addPacket(p, 3, 2);
    runTraffic("start order");
    reportTest();
  endtask

  task automatic testTimeLimit();
    addPacket(2, 2, 5);
    addPacket(3, 2, 5);
    runTraffic("time limit");
    reportTest();
  endtask

  // Local holds the grant long enough for South to fill up
  task automatic testQueueFull();
    addPacket(0, 20, 7);
    addPacket(numPorts - 1, 3, 3);
    runTraffic("queue full");
    checkValue("South full seen", 1, sawSouthFull);
    checkValue("inFull after drain", 0, inFull);
    reportTest();
  endtask

  task automatic testHeaderLatch();
    addPacket(1, 1, 1);
    addPacket(1, 3, 3);
    addPacket(2, 1, 7);
    runTraffic("header latch");
    reportTest();
  endtask

  initial
  begin
    rst = 1'b1;
    inValid = '0;
    inId = '0;
    inLength = '0;
    inData = '0;
    for (int p = 0; p < numPorts; p++)
      modelLimit[p] = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    testReset();
    testSingle();
    testOrder();
    testTimeLimit();
    testQueueFull();
    testHeaderLatch();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: routerOutputPort.f
logic/routerPkg.sv
logic/inputQueue.sv
logic/portTimer.sv
logic/flowArbiter.sv
logic/outputSwitch.sv
logic/routerOutputPort.sv
test/routerOutputPort_assertions.sv
test/routerOutputPort_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	  --top-module routerOutputPort_tb --Mdir obj_dir -f routerOutputPort.f
	./obj_dir/VrouterOutputPort_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Testbench failed" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Testbench passed" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
